/* design/alu_exec.sv */
`include "core_defines.svh"

module alu_exec import core_pkg::*; (
    input logic        clk,
    input logic        rst,
    dispatch_if.exec   dp,
    result_if.exec     res
);

    logic [`DATA_W-1:0] alu_out;
    logic               br_taken;

    always_comb begin
        alu_out  = '0;
        br_taken = 1'b0;
        case (dp.op)
            OP_ADD: alu_out = dp.src_a + dp.src_b;
            OP_SUB: alu_out = dp.src_a - dp.src_b;
            OP_AND: alu_out = dp.src_a & dp.src_b;
            OP_OR:  alu_out = dp.src_a | dp.src_b;
            OP_XOR: alu_out = dp.src_a ^ dp.src_b;
            // branches leave data at zero
            OP_BEQ: br_taken = (dp.src_a == dp.src_b);
            OP_BNE: br_taken = (dp.src_a != dp.src_b);
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= dp.valid;
        end
    end

    always_ff @(posedge clk) begin
        res.tag    <= dp.tag;
        res.data   <= alu_out;
        res.taken  <= br_taken;
        res.target <= dp.pc + dp.imm;
    end

endmodule

/* design/arch_regfile.sv */
`include "core_defines.svh"

module arch_regfile import core_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [4:0]         rs1,
    input  logic [4:0]         rs2,
    output logic [`DATA_W-1:0] rs1_val,
    output logic [`DATA_W-1:0] rs2_val,
    output logic               rs1_busy,
    output logic               rs2_busy,
    input  logic               claim,
    input  logic [4:0]         claim_rd,
    input  rob_tag_t           claim_tag,
    commit_if.rf               cm
);

    logic [`DATA_W-1:0]  regs  [`REG_NUM];
    logic [`REG_NUM-1:0] busy;
    rob_tag_t            owner [`REG_NUM];

    // x0 reads as zero
    assign rs1_val  = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val  = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign rs1_busy = busy[rs1];
    assign rs2_busy = busy[rs2];

    always_ff @(posedge clk) begin
        if (cm.valid && cm.writes_rd) begin
            regs[cm.rd] <= cm.data;
        end
        if (claim) begin
            owner[claim_rd] <= claim_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || cm.flush) begin
            busy <= '0;
        end else begin
            if (cm.valid && cm.writes_rd && (owner[cm.rd] == cm.tag)) begin
                busy[cm.rd] <= 1'b0;
            end
            // a newer claim on the same register wins
            if (claim) begin
                busy[claim_rd] <= 1'b1;
            end
        end
    end

endmodule

/* design/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and pc width
`define DATA_W 32

// architectural registers
`define REG_NUM 32

// reorder buffer entries
`define ROB_DEPTH 8

// tag width must stay log2 of the depth
`define TAG_W 3

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* design/core_ifs.sv */
`include "core_defines.svh"

interface dispatch_if import core_pkg::*; ();
    logic               valid;
    rob_tag_t           tag;
    alu_op_t            op;
    logic [4:0]         rd;
    logic               writes_rd;
    logic [`DATA_W-1:0] src_a;
    logic [`DATA_W-1:0] src_b;
    logic [`DATA_W-1:0] imm;
    logic [`DATA_W-1:0] pc;
    logic               full;
    rob_tag_t           tail_tag;

    modport decode (output valid, tag, op, rd, writes_rd, src_a, src_b, imm, pc,
                    input full, tail_tag);
    modport exec (input valid, tag, op, src_a, src_b, imm, pc);
    modport rob (input valid, tag, rd, writes_rd, output full, tail_tag);
endinterface

interface result_if import core_pkg::*; ();
    logic               valid;
    rob_tag_t           tag;
    logic [`DATA_W-1:0] data;
    logic               taken;
    logic [`DATA_W-1:0] target;

    modport exec (output valid, tag, data, taken, target);
    modport rob (input valid, tag, data, taken, target);
endinterface

interface commit_if import core_pkg::*; ();
    logic               valid;
    logic [4:0]         rd;
    logic               writes_rd;
    logic [`DATA_W-1:0] data;
    rob_tag_t           tag;
    logic               flush;
    logic [`DATA_W-1:0] redirect_pc;

    modport rob (output valid, rd, writes_rd, data, tag, flush, redirect_pc);
    modport rf (input valid, rd, writes_rd, data, tag, flush);
    modport watch (input flush, redirect_pc);
endinterface

/* design/core_pkg.sv */
`include "core_defines.svh"

package core_pkg;

    // reorder buffer slot index
    typedef logic [`TAG_W-1:0] rob_tag_t;

    // operations handled by the ALU
    typedef enum logic [2:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_BEQ,
        OP_BNE
    } alu_op_t;

    // one instruction word seen as R-type or as I/B-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            // rd for I-type, low immediate bits for B-type
            logic [4:0]  rd_imm;
            logic [6:0]  opcode;
        } ib;
    } instr_t;

endpackage

/* design/inst_decode.sv */
`include "core_defines.svh"

module inst_decode import core_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    output logic [`DATA_W-1:0] fetch_pc,
    input  logic               instr_valid,
    input  instr_t             instr,
    output logic               stall,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    input  logic [`DATA_W-1:0] rs1_val,
    input  logic [`DATA_W-1:0] rs2_val,
    input  logic               rs1_busy,
    input  logic               rs2_busy,
    output logic               claim,
    output logic [4:0]         claim_rd,
    output rob_tag_t           claim_tag,
    dispatch_if.decode         dp,
    commit_if.watch            cm
);

    localparam logic [6:0] OPC_R = 7'b0110011;
    localparam logic [6:0] OPC_I = 7'b0010011;
    localparam logic [6:0] OPC_B = 7'b1100011;

    logic               hold_valid;
    instr_t             hold_instr;
    logic [`DATA_W-1:0] hold_pc;
    alu_op_t            op;
    logic               use_rs1;
    logic               use_rs2;
    logic               use_imm;
    logic               writes;
    logic [`DATA_W-1:0] imm;
    logic [`DATA_W-1:0] i_imm;
    logic [`DATA_W-1:0] b_imm;
    logic               src_busy;
    logic               issue;
    logic               accept;

    // immediates come from the I/B view
    assign i_imm = {{(`DATA_W-12){hold_instr.ib.imm[11]}}, hold_instr.ib.imm};
    assign b_imm = {{(`DATA_W-12){hold_instr.ib.imm[11]}}, hold_instr.ib.rd_imm[0],
                    hold_instr.ib.imm[10:5], hold_instr.ib.rd_imm[4:1], 1'b0};

    always_comb begin
        op      = OP_NOP;
        use_imm = 1'b0;
        imm     = '0;
        case (hold_instr.r.opcode)
            OPC_R: begin
                case ({hold_instr.r.funct7, hold_instr.r.funct3})
                    {7'b0000000, 3'b000}: op = OP_ADD;
                    {7'b0100000, 3'b000}: op = OP_SUB;
                    {7'b0000000, 3'b100}: op = OP_XOR;
                    {7'b0000000, 3'b110}: op = OP_OR;
                    {7'b0000000, 3'b111}: op = OP_AND;
                    default: op = OP_NOP;
                endcase
            end
            OPC_I: begin
                // only ADDI
                if (hold_instr.r.funct3 == 3'b000) begin
                    op      = OP_ADD;
                    use_imm = 1'b1;
                    imm     = i_imm;
                end
            end
            OPC_B: begin
                imm = b_imm;
                if (hold_instr.r.funct3 == 3'b000) begin
                    op = OP_BEQ;
                end else if (hold_instr.r.funct3 == 3'b001) begin
                    op = OP_BNE;
                end
            end
            default: op = OP_NOP;
        endcase
    end

    assign use_rs1 = (op != OP_NOP);
    assign use_rs2 = use_rs1 && !use_imm;
    assign writes  = (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR}) &&
                     (hold_instr.r.rd != 5'd0);

    assign rs1 = hold_instr.r.rs1;
    assign rs2 = hold_instr.r.rs2;

    // no forwarding, wait until sources have committed
    assign src_busy = (use_rs1 && rs1_busy) || (use_rs2 && rs2_busy);
    assign issue    = hold_valid && !dp.full && !src_busy && !cm.flush;
    assign stall    = hold_valid && !issue;
    assign accept   = instr_valid && !stall && !cm.flush;

    assign claim     = issue && writes;
    assign claim_rd  = hold_instr.r.rd;
    assign claim_tag = dp.tail_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc   <= `RESET_PC;
            hold_valid <= 1'b0;
            dp.valid   <= 1'b0;
        end else if (cm.flush) begin
            // drop the held instruction and restart at the target
            fetch_pc   <= cm.redirect_pc;
            hold_valid <= 1'b0;
            dp.valid   <= 1'b0;
        end else begin
            dp.valid <= issue;
            if (accept) begin
                fetch_pc   <= fetch_pc + `DATA_W'd4;
                hold_valid <= 1'b1;
            end else if (issue) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hold_instr <= instr;
            hold_pc    <= fetch_pc;
        end
        if (issue) begin
            dp.tag       <= dp.tail_tag;
            dp.op        <= op;
            dp.rd        <= hold_instr.r.rd;
            dp.writes_rd <= writes;
            dp.src_a     <= rs1_val;
            dp.src_b     <= use_imm ? imm : rs2_val;
            dp.imm       <= imm;
            dp.pc        <= hold_pc;
        end
    end

endmodule

/* design/ooo_core.sv */
`include "core_defines.svh"

module ooo_core import core_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    output logic [`DATA_W-1:0] fetch_pc,
    input  logic               instr_valid,
    input  logic [31:0]        instr,
    output logic               stall,
    output logic               commit_valid,
    output logic [4:0]         commit_rd,
    output logic               commit_writes,
    output logic [`DATA_W-1:0] commit_data,
    output logic [`TAG_W-1:0]  commit_tag,
    output logic               flush,
    output logic [`DATA_W-1:0] redirect_pc
);

    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [`DATA_W-1:0] rs1_val;
    logic [`DATA_W-1:0] rs2_val;
    logic               rs1_busy;
    logic               rs2_busy;
    logic               claim;
    logic [4:0]         claim_rd;
    rob_tag_t           claim_tag;

    dispatch_if dp_if ();
    result_if   res_if ();
    commit_if   cm_if ();

    inst_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .fetch_pc    (fetch_pc),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .rs1_busy    (rs1_busy),
        .rs2_busy    (rs2_busy),
        .claim       (claim),
        .claim_rd    (claim_rd),
        .claim_tag   (claim_tag),
        .dp          (dp_if.decode),
        .cm          (cm_if.watch)
    );

    alu_exec u_exec (
        .clk (clk),
        .rst (rst),
        .dp  (dp_if.exec),
        .res (res_if.exec)
    );

    reorder_buffer u_rob (
        .clk (clk),
        .rst (rst),
        .dp  (dp_if.rob),
        .res (res_if.rob),
        .cm  (cm_if.rob)
    );

    arch_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .rs1_busy  (rs1_busy),
        .rs2_busy  (rs2_busy),
        .claim     (claim),
        .claim_rd  (claim_rd),
        .claim_tag (claim_tag),
        .cm        (cm_if.rf)
    );

    // commit stream straight from the reorder buffer
    assign commit_valid  = cm_if.valid;
    assign commit_rd     = cm_if.rd;
    assign commit_writes = cm_if.writes_rd;
    assign commit_data   = cm_if.data;
    assign commit_tag    = cm_if.tag;
    assign flush         = cm_if.flush;
    assign redirect_pc   = cm_if.redirect_pc;

endmodule

/* design/reorder_buffer.sv */
`include "core_defines.svh"

module reorder_buffer import core_pkg::*; (
    input logic      clk,
    input logic      rst,
    dispatch_if.rob  dp,
    result_if.rob    res,
    commit_if.rob    cm
);

    localparam logic [`TAG_W:0] DEPTH_CNT = `ROB_DEPTH;

    logic [`ROB_DEPTH-1:0] ent_valid;
    logic [`ROB_DEPTH-1:0] ent_done;
    logic [4:0]            ent_rd     [`ROB_DEPTH];
    logic                  ent_writes [`ROB_DEPTH];
    logic [`DATA_W-1:0]    ent_data   [`ROB_DEPTH];
    logic                  ent_taken  [`ROB_DEPTH];
    logic [`DATA_W-1:0]    ent_target [`ROB_DEPTH];

    rob_tag_t              head;
    rob_tag_t              tail;
    logic [`TAG_W:0]       count;
    logic [`TAG_W:0]       count_pend;
    logic                  commit_fire;

    // a dispatch already on the bus holds its slot too
    assign count_pend  = count + {{`TAG_W{1'b0}}, dp.valid};
    assign dp.full     = (count_pend == DEPTH_CNT);
    assign dp.tail_tag = dp.valid ? rob_tag_t'(tail + 1'b1) : tail;

    // nothing commits in the flush cycle
    assign commit_fire = ent_valid[head] && ent_done[head] && !cm.flush;

    always_ff @(posedge clk) begin
        if (rst || cm.flush) begin
            ent_valid <= '0;
            ent_done  <= '0;
            head      <= '0;
            tail      <= '0;
            count     <= '0;
        end else begin
            if (dp.valid) begin
                ent_valid[dp.tag] <= 1'b1;
                ent_done[dp.tag]  <= 1'b0;
                tail              <= tail + 1'b1;
            end
            // stale results from before a flush find no valid entry
            if (res.valid && ent_valid[res.tag]) begin
                ent_done[res.tag] <= 1'b1;
            end
            if (commit_fire) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            count <= count_pend - {{`TAG_W{1'b0}}, commit_fire};
        end
    end

    always_ff @(posedge clk) begin
        if (dp.valid) begin
            ent_rd[dp.tag]     <= dp.rd;
            ent_writes[dp.tag] <= dp.writes_rd;
        end
        if (res.valid) begin
            ent_data[res.tag]   <= res.data;
            ent_taken[res.tag]  <= res.taken;
            ent_target[res.tag] <= res.target;
        end
    end

    // predicted not taken, so any taken branch at the head flushes
    always_ff @(posedge clk) begin
        if (rst) begin
            cm.valid     <= 1'b0;
            cm.writes_rd <= 1'b0;
            cm.flush     <= 1'b0;
        end else begin
            cm.valid     <= commit_fire;
            cm.writes_rd <= commit_fire && ent_writes[head];
            cm.flush     <= commit_fire && ent_taken[head];
        end
    end

    always_ff @(posedge clk) begin
        if (commit_fire) begin
            cm.rd          <= ent_rd[head];
            cm.data        <= ent_data[head];
            cm.tag         <= head;
            cm.redirect_pc <= ent_target[head];
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ooo_core -f verilog.f \
    -o sim_ooo_core && ./obj_dir/sim_ooo_core > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* testbench/ooo_core_props.sv */
`include "core_defines.svh"

module ooo_core_props (
    input logic              clk,
    input logic              rst,
    input logic              stall,
    input logic              commit_valid,
    input logic [4:0]        commit_rd,
    input logic              commit_writes,
    input logic [`TAG_W-1:0] commit_tag,
    input logic              flush
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`TAG_W-1:0] last_tag;
    logic              last_flush;
    logic              seen_commit;
    int                fail_count = 0;

    // previous commit, for the tag sequence
    always_ff @(posedge clk) begin
        if (rst) begin
            seen_commit <= 1'b0;
            last_flush  <= 1'b0;
            last_tag    <= '0;
        end else if (commit_valid) begin
            seen_commit <= 1'b1;
            last_flush  <= flush;
            last_tag    <= commit_tag;
        end
    end

    a_flush_with_commit: assert property (@(posedge clk) disable iff (rst)
        flush |-> (commit_valid && !commit_writes))
        else begin
            $error("flush seen without a non-writing branch commit");
            fail_count++;
        end

    a_tag_in_order: assert property (@(posedge clk) disable iff (rst)
        (commit_valid && seen_commit && !last_flush) |->
            (commit_tag == `TAG_W'(last_tag + 1'b1)))
        else begin
            $error("commit tag skipped or repeated");
            fail_count++;
        end

    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        (commit_valid && commit_writes) |-> (commit_rd != 5'd0))
        else begin
            $error("commit writes x0");
            fail_count++;
        end

    a_stall_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !stall)
        else begin
            $error("stall high right after reset");
            fail_count++;
        end

endmodule

bind ooo_core ooo_core_props u_props (
    .clk           (clk),
    .rst           (rst),
    .stall         (stall),
    .commit_valid  (commit_valid),
    .commit_rd     (commit_rd),
    .commit_writes (commit_writes),
    .commit_tag    (commit_tag),
    .flush         (flush)
);

/* testbench/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

/* testbench/tb_ooo_core.sv */
`include "core_defines.svh"

module tb_ooo_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS     = 4;
    localparam int PROG_LEN   = 28;
    localparam int LOOP_LAPS  = 3;
    localparam int MAX_COMMIT = 128;

    // instruction kinds of the program table
    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_XOR  = 4;
    localparam int K_ADDI = 5;
    localparam int K_BEQ  = 6;
    localparam int K_BNE  = 7;
    localparam int K_NOP  = 8;

    logic               clk;
    logic               rst;
    logic [`DATA_W-1:0] fetch_pc;
    logic               instr_valid;
    logic [31:0]        instr;
    logic               stall;
    logic               commit_valid;
    logic [4:0]         commit_rd;
    logic               commit_writes;
    logic [`DATA_W-1:0] commit_data;
    logic [`TAG_W-1:0]  commit_tag;
    logic               flush;
    logic [`DATA_W-1:0] redirect_pc;

    int          prog_kind [PROG_LEN];
    int          prog_rd   [PROG_LEN];
    int          prog_rs1  [PROG_LEN];
    int          prog_rs2  [PROG_LEN];
    int          prog_imm  [PROG_LEN];
    logic [31:0] prog_word [PROG_LEN];

    // expected commit stream
    int          exp_count;
    int          exp_rd     [MAX_COMMIT];
    bit          exp_wr     [MAX_COMMIT];
    logic [31:0] exp_data   [MAX_COMMIT];
    bit          exp_taken  [MAX_COMMIT];
    logic [31:0] exp_target [MAX_COMMIT];
    int          exp_tag    [MAX_COMMIT];

    logic [31:0] lfsr;
    int          fetch_idx;
    bit          stall_seen;

    tb_clock_gen #(.PERIOD_NS(4.0)) u_clk (.clk(clk));

    ooo_core u_dut (
        .clk           (clk),
        .rst           (rst),
        .fetch_pc      (fetch_pc),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .stall         (stall),
        .commit_valid  (commit_valid),
        .commit_rd     (commit_rd),
        .commit_writes (commit_writes),
        .commit_data   (commit_data),
        .commit_tag    (commit_tag),
        .flush         (flush),
        .redirect_pc   (redirect_pc)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        // taps 32 22 2 1
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // RV32I encodings
    function automatic logic [31:0] encode(input int kind, input int rd, input int rs1,
                                           input int rs2, input int imm);
        logic [4:0]  d;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [12:0] b;
        logic [31:0] w;
        d  = 5'(rd);
        s1 = 5'(rs1);
        s2 = 5'(rs2);
        b  = 13'(imm);
        case (kind)
            K_ADD:   w = {7'h00, s2, s1, 3'b000, d, 7'b0110011};
            K_SUB:   w = {7'h20, s2, s1, 3'b000, d, 7'b0110011};
            K_AND:   w = {7'h00, s2, s1, 3'b111, d, 7'b0110011};
            K_OR:    w = {7'h00, s2, s1, 3'b110, d, 7'b0110011};
            K_XOR:   w = {7'h00, s2, s1, 3'b100, d, 7'b0110011};
            K_ADDI:  w = {imm[11:0], s1, 3'b000, d, 7'b0010011};
            K_BEQ:   w = {b[12], b[10:5], s2, s1, 3'b000, b[4:1], b[11], 7'b1100011};
            K_BNE:   w = {b[12], b[10:5], s2, s1, 3'b001, b[4:1], b[11], 7'b1100011};
            // lui, outside the supported set
            default: w = {20'h12345, d, 7'b0110111};
        endcase
        return w;
    endfunction

    task automatic put_instr(input int idx, input int kind, input int rd, input int rs1,
                             input int rs2, input int imm);
        prog_kind[idx] = kind;
        prog_rd[idx]   = rd;
        prog_rs1[idx]  = rs1;
        prog_rs2[idx]  = rs2;
        prog_imm[idx]  = imm;
        prog_word[idx] = encode(kind, rd, rs1, rs2, imm);
    endtask

    task automatic load_program();
        put_instr(0, K_ADDI, 1, 0, 0, 5);
        put_instr(1, K_ADDI, 2, 0, 0, -3);
        put_instr(2, K_ADD, 3, 1, 2, 0);
        put_instr(3, K_SUB, 4, 3, 1, 0);
        put_instr(4, K_AND, 5, 4, 1, 0);
        put_instr(5, K_OR, 6, 5, 2, 0);
        put_instr(6, K_XOR, 7, 6, 3, 0);
        put_instr(7, K_ADD, 0, 1, 2, 0);
        put_instr(8, K_ADDI, 8, 0, 0, 0);
        put_instr(9, K_NOP, 9, 0, 0, 0);
        put_instr(10, K_BEQ, 0, 1, 2, 8);
        put_instr(11, K_BNE, 0, 3, 3, 8);
        put_instr(12, K_BNE, 0, 1, 2, 12);
        // wrong path of the taken BNE
        put_instr(13, K_ADDI, 9, 0, 0, 99);
        put_instr(14, K_ADDI, 10, 0, 0, 77);
        put_instr(15, K_ADD, 11, 7, 1, 0);
        // independent run
        for (int k = 0; k < 8; k++) begin
            put_instr(16 + k, K_ADDI, 12 + k, 0, 0, k * 7 + 1);
        end
        put_instr(24, K_BEQ, 0, 12, 12, 8);
        put_instr(25, K_XOR, 20, 1, 1, 0);
        put_instr(26, K_SUB, 21, 19, 11, 0);
        put_instr(27, K_BEQ, 0, 0, 0, 0);
    endtask

    // sequential model with not-taken prediction
    task automatic build_expected();
        logic [31:0] regs [32];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] pc;
        bit          taken;
        int          idx;
        int          laps;
        int          tag;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc        = `RESET_PC;
        laps      = 0;
        tag       = 0;
        exp_count = 0;
        while (laps < LOOP_LAPS && exp_count < MAX_COMMIT) begin
            idx = int'(pc >> 2);
            if (idx >= PROG_LEN) begin
                break;
            end
            a     = regs[prog_rs1[idx]];
            b     = (prog_kind[idx] == K_ADDI) ? 32'(prog_imm[idx]) : regs[prog_rs2[idx]];
            res   = '0;
            taken = 1'b0;
            case (prog_kind[idx])
                K_ADD, K_ADDI: res = a + b;
                K_SUB:         res = a - b;
                K_AND:         res = a & b;
                K_OR:          res = a | b;
                K_XOR:         res = a ^ b;
                K_BEQ:         taken = (a == b);
                K_BNE:         taken = (a != b);
                default:       res = '0;
            endcase
            exp_rd[exp_count]     = prog_rd[idx];
            exp_wr[exp_count]     = (prog_kind[idx] <= K_ADDI) && (prog_rd[idx] != 0);
            exp_data[exp_count]   = res;
            exp_taken[exp_count]  = taken;
            exp_target[exp_count] = pc + 32'(prog_imm[idx]);
            exp_tag[exp_count]    = tag;
            if (exp_wr[exp_count]) begin
                regs[prog_rd[idx]] = res;
            end
            exp_count++;
            if (taken) begin
                pc  = pc + 32'(prog_imm[idx]);
                tag = 0;
                if (idx == PROG_LEN - 1) begin
                    laps++;
                end
            end else begin
                pc  = pc + 32'd4;
                tag = (tag + 1) % `ROB_DEPTH;
            end
        end
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic wait_commit();
        @(negedge clk);
        while (!commit_valid) begin
            @(negedge clk);
        end
    endtask

    // instruction memory with random fetch gaps
    always @(posedge clk) begin
        #0.5;
        lfsr      = lfsr_step(lfsr);
        fetch_idx = int'(fetch_pc >> 2);
        if (lfsr[0] || fetch_idx >= PROG_LEN) begin
            instr_valid = 1'b0;
            instr       = '0;
        end else begin
            instr_valid = 1'b1;
            instr       = prog_word[fetch_idx];
        end
    end

    always @(negedge clk) begin
        if (!rst && stall) begin
            stall_seen = 1'b1;
        end
    end

    // stop at the first failed bound assertion
    always @(negedge clk) begin
        if (u_dut.u_props.fail_count != 0) begin
            $display("a bound assertion on the core failed, see the error above");
            $display("Finished with errors");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        #((PROG_LEN * 40 + 8) * CLK_NS);
        $display("watchdog timeout: the commit stream did not finish in time");
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr        = 32'hb5f50e62;
        stall_seen  = 1'b0;
        load_program();
        build_expected();
        repeat (8) @(posedge clk);
        #0.5;
        rst = 1'b0;
        for (int i = 0; i < exp_count; i++) begin
            wait_commit();
            check("commit_tag", 32'(exp_tag[i]), 32'(commit_tag));
            check("commit_writes", 32'(exp_wr[i]), 32'(commit_writes));
            if (exp_wr[i]) begin
                check("commit_rd", 32'(exp_rd[i]), 32'(commit_rd));
                check("commit_data", exp_data[i], commit_data);
            end
            check("flush", 32'(exp_taken[i]), 32'(flush));
            if (exp_taken[i]) begin
                check("redirect_pc", exp_target[i], redirect_pc);
            end
        end
        check("stall_seen", 32'd1, 32'(stall_seen));
        check("assertion_failures", 32'd0, 32'(u_dut.u_props.fail_count));
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+design
design/core_pkg.sv
design/core_ifs.sv
design/inst_decode.sv
design/alu_exec.sv
design/reorder_buffer.sv
design/arch_regfile.sv
design/ooo_core.sv
testbench/tb_clock_gen.sv
testbench/ooo_core_props.sv
testbench/tb_ooo_core.sv
